//--- hw/rv_pkg.sv
package rv_pkg;

    // ==================================================
    // Widths with a meaning
    // ==================================================
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [3:0]  byte_en_t;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jalr   = 7'b1100111,
        opc_jal    = 7'b1101111,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    // Which value leaves execute as the result
    typedef enum logic [1:0] {res_alu, res_lui, res_auipc, res_link} res_sel_e;

    typedef enum logic [1:0] {fwd_none, fwd_mem, fwd_wb} fwd_sel_e;

    // ==================================================
    // Decoded controls and pipeline registers
    // ==================================================
    typedef struct packed {
        logic     reg_we;
        logic     mem_we;
        logic     mem_read;
        logic     branch;
        logic     jump;
        logic     is_jalr;
        logic     use_imm;
        logic     halt;
        alu_op_e  alu_op;
        res_sel_e res_sel;
    } ctrl_t;

    typedef struct packed {
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        funct3_t   funct3;
        ctrl_t     ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t     pc;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t rd;
        logic      reg_we;
        logic      mem_we;
        logic      mem_read;
        logic      halt;
    } ex_mem_t;

    typedef struct packed {
        word_t     pc;
        word_t     result;
        reg_addr_t rd;
        logic      reg_we;
        logic      mem_read;
        logic      halt;
    } mem_wb_t;

    typedef struct packed {
        word_t    addr;
        word_t    wdata;
        byte_en_t we;
    } dmem_req_t;

endpackage

//--- hw/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  rv_pkg::reg_addr_t rd,
    input  logic              we,
    input  rv_pkg::word_t     wdata,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);
    import rv_pkg::*;

    word_t regs [32];
    logic  wr_live;

    // x0 is never written, so it reads as zero
    assign wr_live = we && (rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[rd] <= wdata;
        end
    end

    // Write-through so decode sees this cycle's writeback
    assign rs1_data = (wr_live && rd == rs1) ? wdata : regs[rs1];
    assign rs2_data = (wr_live && rd == rs2) ? wdata : regs[rs2];

endmodule

//--- hw/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  rv_pkg::word_t     inst,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2,
    output rv_pkg::reg_addr_t rd,
    output rv_pkg::funct3_t   funct3,
    output rv_pkg::word_t     imm,
    output rv_pkg::ctrl_t     ctrl
);
    import rv_pkg::*;

    opcode_e opcode;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;
    word_t   imm_j;

    // funct3 to ALU operation, alt picks SUB or SRA
    function automatic alu_op_e alu_from_funct3(input funct3_t f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = opcode_e'(inst[6:0]);
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];

    // Unused source fields read as x0 so they never stall or forward
    assign rs1 = (opcode inside {opc_op, opc_op_imm, opc_load, opc_store, opc_branch, opc_jalr})
               ? inst[19:15] : '0;
    assign rs2 = (opcode inside {opc_op, opc_store, opc_branch}) ? inst[24:20] : '0;

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        ctrl = '0;
        imm  = imm_i;
        case (opcode)
            opc_op: begin
                ctrl.reg_we = 1'b1;
                ctrl.alu_op = alu_from_funct3(funct3, inst[30]);
            end
            opc_op_imm: begin
                ctrl.reg_we  = 1'b1;
                ctrl.use_imm = 1'b1;
                // Bit 30 is part of the immediate except for shifts right
                ctrl.alu_op  = alu_from_funct3(funct3, inst[30] && funct3 == 3'b101);
            end
            opc_load: begin
                ctrl.reg_we   = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.use_imm  = 1'b1;
            end
            opc_store: begin
                ctrl.mem_we  = 1'b1;
                ctrl.use_imm = 1'b1;
                imm          = imm_s;
            end
            opc_branch: begin
                ctrl.branch = 1'b1;
                imm         = imm_b;
            end
            opc_jal: begin
                ctrl.reg_we  = 1'b1;
                ctrl.jump    = 1'b1;
                ctrl.res_sel = res_link;
                imm          = imm_j;
            end
            opc_jalr: begin
                ctrl.reg_we  = 1'b1;
                ctrl.jump    = 1'b1;
                ctrl.is_jalr = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.res_sel = res_link;
            end
            opc_lui: begin
                ctrl.reg_we  = 1'b1;
                ctrl.res_sel = res_lui;
                imm          = imm_u;
            end
            opc_auipc: begin
                ctrl.reg_we  = 1'b1;
                ctrl.res_sel = res_auipc;
                imm          = imm_u;
            end
            // ECALL only, EBREAK and CSR forms are ignored
            opc_system: ctrl.halt = (funct3 == 3'b000) && !inst[20];
            default: ;
        endcase
    end

endmodule

//--- hw/rv_hazard.sv
`timescale 1ns/1ps

module rv_hazard (
    input  rv_pkg::reg_addr_t id_rs1,
    input  rv_pkg::reg_addr_t id_rs2,
    input  rv_pkg::reg_addr_t ex_rd,
    input  logic              ex_mem_read,
    input  rv_pkg::reg_addr_t ex_rs1,
    input  rv_pkg::reg_addr_t ex_rs2,
    input  rv_pkg::reg_addr_t mem_rd,
    input  rv_pkg::reg_addr_t wb_rd,
    input  logic              mem_reg_we,
    input  logic              wb_reg_we,
    output logic              stall,
    output rv_pkg::fwd_sel_e  fwd_a,
    output rv_pkg::fwd_sel_e  fwd_b
);
    import rv_pkg::*;

    // Youngest producer wins, x0 is never forwarded
    function automatic fwd_sel_e pick_fwd(input reg_addr_t src, input reg_addr_t m_rd,
                                          input logic m_we, input reg_addr_t w_rd,
                                          input logic w_we);
        if (src == '0) return fwd_none;
        if (m_we && m_rd == src) return fwd_mem;
        if (w_we && w_rd == src) return fwd_wb;
        return fwd_none;
    endfunction

    // Load data is not ready until writeback, so hold one cycle
    assign stall = ex_mem_read && (ex_rd != '0) && ((ex_rd == id_rs1) || (ex_rd == id_rs2));

    assign fwd_a = pick_fwd(ex_rs1, mem_rd, mem_reg_we, wb_rd, wb_reg_we);
    assign fwd_b = pick_fwd(ex_rs2, mem_rd, mem_reg_we, wb_rd, wb_reg_we);

endmodule

//--- hw/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::id_ex_t ex,
    input  rv_pkg::word_t  op_a,
    input  rv_pkg::word_t  op_b_reg,
    output rv_pkg::word_t  result,
    output logic           redirect,
    output rv_pkg::word_t  target
);
    import rv_pkg::*;

    word_t op_b;
    word_t alu_out;
    logic  take;

    assign op_b = ex.ctrl.use_imm ? ex.imm : op_b_reg;

    always_comb begin
        case (ex.ctrl.alu_op)
            alu_add:  alu_out = op_a + op_b;
            alu_sub:  alu_out = op_a - op_b;
            alu_sll:  alu_out = op_a << op_b[4:0];
            alu_slt:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_out = {31'b0, op_a < op_b};
            alu_xor:  alu_out = op_a ^ op_b;
            alu_srl:  alu_out = op_a >> op_b[4:0];
            alu_sra:  alu_out = word_t'($signed(op_a) >>> op_b[4:0]);
            alu_or:   alu_out = op_a | op_b;
            default:  alu_out = op_a & op_b;
        endcase
    end

    // Upper-immediate and link results bypass the ALU
    always_comb begin
        case (ex.ctrl.res_sel)
            res_lui:   result = ex.imm;
            res_auipc: result = ex.pc + ex.imm;
            res_link:  result = ex.pc + 32'd4;
            default:   result = alu_out;
        endcase
    end

    // Branch compare always on the two register operands
    always_comb begin
        case (ex.funct3)
            3'b000:  take = (op_a == op_b_reg);
            3'b001:  take = (op_a != op_b_reg);
            3'b100:  take = ($signed(op_a) < $signed(op_b_reg));
            3'b101:  take = ($signed(op_a) >= $signed(op_b_reg));
            3'b110:  take = (op_a < op_b_reg);
            3'b111:  take = (op_a >= op_b_reg);
            default: take = 1'b0;
        endcase
    end

    assign redirect = (ex.ctrl.branch && take) || ex.ctrl.jump;

    assign target = ex.ctrl.is_jalr ? ((op_a + ex.imm) & ~32'd1) : (ex.pc + ex.imm);

endmodule

//--- hw/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic              clk,
    input  logic              rst,
    output rv_pkg::word_t     imem_addr,
    input  rv_pkg::word_t     imem_data,
    output rv_pkg::dmem_req_t dmem_req,
    input  rv_pkg::word_t     dmem_rdata,
    output logic              halt,
    output rv_pkg::word_t     wb_pc
);
    import rv_pkg::*;

    word_t     pc;
    word_t     if_id_pc;
    word_t     if_id_inst;

    reg_addr_t id_rs1;
    reg_addr_t id_rs2;
    reg_addr_t id_rd;
    funct3_t   id_funct3;
    word_t     id_imm;
    ctrl_t     id_ctrl;
    word_t     id_rs1_data;
    word_t     id_rs2_data;

    logic      stall;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;

    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;

    word_t     ex_op_a;
    word_t     ex_op_b;
    word_t     ex_result;
    word_t     ex_target;
    logic      redirect;
    word_t     wb_data;

    // ==================================================
    // Fetch
    // ==================================================
    assign imem_addr = pc;

    // Redirect and stall never coincide, a load cannot branch
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= ex_target;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    // An all-zero instruction decodes as a bubble
    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            if_id_pc   <= '0;
            if_id_inst <= '0;
        end else if (!stall) begin
            if_id_pc   <= pc;
            if_id_inst <= imem_data;
        end
    end

    // ==================================================
    // Decode
    // ==================================================
    rv_decode u_decode (
        .inst   (if_id_inst),
        .rs1    (id_rs1),
        .rs2    (id_rs2),
        .rd     (id_rd),
        .funct3 (id_funct3),
        .imm    (id_imm),
        .ctrl   (id_ctrl)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1      (id_rs1),
        .rs2      (id_rs2),
        .rd       (mem_wb.rd),
        .we       (mem_wb.reg_we),
        .wdata    (wb_data),
        .rs1_data (id_rs1_data),
        .rs2_data (id_rs2_data)
    );

    rv_hazard u_hazard (
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .ex_rd       (id_ex.rd),
        .ex_mem_read (id_ex.ctrl.mem_read),
        .ex_rs1      (id_ex.rs1),
        .ex_rs2      (id_ex.rs2),
        .mem_rd      (ex_mem.rd),
        .wb_rd       (mem_wb.rd),
        .mem_reg_we  (ex_mem.reg_we),
        .wb_reg_we   (mem_wb.reg_we),
        .stall       (stall),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b)
    );

    // Bubble on a load-use stall or a taken redirect
    always_ff @(posedge clk) begin
        if (rst || redirect || stall) begin
            id_ex <= '0;
        end else begin
            id_ex <= '{pc: if_id_pc, rs1_data: id_rs1_data, rs2_data: id_rs2_data,
                       imm: id_imm, rs1: id_rs1, rs2: id_rs2, rd: id_rd,
                       funct3: id_funct3, ctrl: id_ctrl};
        end
    end

    // ==================================================
    // Execute
    // ==================================================
    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign ex_op_a = fwd_mux(fwd_a, id_ex.rs1_data, ex_mem.alu_result, wb_data);
    assign ex_op_b = fwd_mux(fwd_b, id_ex.rs2_data, ex_mem.alu_result, wb_data);

    rv_alu u_alu (
        .ex       (id_ex),
        .op_a     (ex_op_a),
        .op_b_reg (ex_op_b),
        .result   (ex_result),
        .redirect (redirect),
        .target   (ex_target)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= '{pc: id_ex.pc, alu_result: ex_result, store_data: ex_op_b,
                        rd: id_ex.rd, reg_we: id_ex.ctrl.reg_we,
                        mem_we: id_ex.ctrl.mem_we, mem_read: id_ex.ctrl.mem_read,
                        halt: id_ex.ctrl.halt};
        end
    end

    // ==================================================
    // Memory access and writeback
    // ==================================================
    assign dmem_req.addr  = ex_mem.alu_result;
    assign dmem_req.wdata = ex_mem.store_data;
    assign dmem_req.we    = ex_mem.mem_we ? 4'b1111 : 4'b0000;

    // Load data or ALU result, chosen as the stage register loads
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= '{pc: ex_mem.pc,
                        result: ex_mem.mem_read ? dmem_rdata : ex_mem.alu_result,
                        rd: ex_mem.rd, reg_we: ex_mem.reg_we,
                        mem_read: ex_mem.mem_read, halt: ex_mem.halt};
        end
    end

    assign wb_data = mem_wb.result;
    assign halt    = mem_wb.halt;
    assign wb_pc   = mem_wb.pc;

endmodule

//--- verif/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;
    import rv_pkg::*;

    localparam int    imem_words    = 256;
    localparam int    dmem_words    = 512;
    localparam word_t branch_marker = 32'hb7a9_c001;
    localparam word_t jump_marker   = 32'h6e15_2d40;

    logic      clk = 1'b0;
    logic      rst;
    word_t     imem_addr;
    word_t     imem_data;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;
    logic      halt;
    word_t     wb_pc;

    word_t imem [imem_words];
    word_t dmem [dmem_words];
    logic  store_seen [dmem_words];
    logic  exp_valid [dmem_words];
    word_t exp_word [dmem_words];
    word_t prog [$];
    word_t ecall_pc;
    word_t rng_state = 32'h8b0a;
    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    cycle_count = 0;
    int    cycle_limit = 16;

    rv_core #(.RESET_PC(32'h0)) u_dut (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .halt       (halt),
        .wb_pc      (wb_pc)
    );

    always #20 clk = ~clk;

    // Limit grows with each program loaded
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: halt was not seen after %0d cycles", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ==================================================
    // Memory models
    // ==================================================
    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = rst ? '0 : dmem[dmem_req.addr[10:2]];

    // Refilled on every reset cycle
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < dmem_words; i++) begin
                dmem[i]       <= fill_word(word_t'(i) << 2);
                store_seen[i] <= 1'b0;
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_req.we[b]) begin
                    dmem[dmem_req.addr[10:2]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
                end
            end
            if (dmem_req.we != '0) begin
                store_seen[dmem_req.addr[10:2]] <= 1'b1;
            end
        end
    end

    // ==================================================
    // Assertions
    // ==================================================
    function automatic logic store_ok(input dmem_req_t req);
        return req.we == 4'hf && req.addr[31:11] == '0 && req.addr[1:0] == 2'b00
            && exp_valid[req.addr[10:2]] && exp_word[req.addr[10:2]] == req.wdata;
    endfunction

    store_check: assert property (@(posedge clk) disable iff (rst)
        dmem_req.we != '0 |-> store_ok(dmem_req))
    else begin
        errors++;
        $display("Mismatch at %0t: store of %h to %h not expected", $time,
                 $sampled(dmem_req.wdata), $sampled(dmem_req.addr));
    end

    reset_quiet: assert property (@(posedge clk) $past(rst) |-> dmem_req.we == '0 && !halt)
    else begin
        errors++;
        $display("Mismatch at %0t: store enable or halt active in reset", $time);
    end

    halt_pc: assert property (@(posedge clk) disable iff (rst) halt |-> wb_pc == ecall_pc)
    else begin
        errors++;
        $display("Mismatch at %0t: halt with wb_pc %h, expected %h", $time,
                 $sampled(wb_pc), ecall_pc);
    end

    // ==================================================
    // Encoders and program helpers
    // ==================================================
    function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input funct3_t f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input funct3_t f3, input reg_addr_t rd,
                                     input opcode_e opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
    endfunction

    function automatic word_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd,
                                     input opcode_e opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t j_type(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    function automatic word_t xorshift(input word_t s);
        word_t x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic void emit(input word_t inst);
        prog.push_back(inst);
    endfunction

    function automatic word_t next_pc();
        return word_t'(prog.size()) << 2;
    endfunction

    // LUI then ADDI with the upper part rounded for the sign of the low 12 bits
    function automatic void load_const(input reg_addr_t rd, input word_t v);
        word_t hi;
        hi = v + 32'h800;
        emit(u_type(hi[31:12], rd, opc_lui));
        emit(i_type(v[11:0], rd, 3'b000, rd, opc_op_imm));
    endfunction

    function automatic void store_checked(input reg_addr_t src, input word_t addr,
                                          input word_t value);
        emit(s_type(addr[11:0], src, 5'd0));
        exp_valid[addr[10:2]] = 1'b1;
        exp_word[addr[10:2]]  = value;
    endfunction

    // More ECALLs and a store trail the halt and are still in flight when reset hits
    function automatic void end_with_ecall();
        ecall_pc = next_pc();
        emit(32'h0000_0073);
        emit(32'h0000_0073);
        emit(32'h0000_0073);
        emit(s_type(12'h7fc, 5'd0, 5'd0));
    endfunction

    function automatic logic branch_taken(input funct3_t f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // ==================================================
    // Programs
    // ==================================================
    function automatic void alu_chain_program();
        word_t       v [10];
        word_t       r;
        logic [11:0] imm;
        for (int k = 0; k < 2; k++) begin
            v[1] = next_rand();
            v[2] = next_rand();
            r    = next_rand();
            imm  = r[11:0];
            load_const(5'd1, v[1]);
            load_const(5'd2, v[2]);
            emit(i_type(imm, 5'd1, 3'b000, 5'd3, opc_op_imm));
            emit(r_type(7'h00, 5'd2, 5'd3, 3'b000, 5'd4));
            emit(r_type(7'h20, 5'd3, 5'd4, 3'b000, 5'd5));
            emit(r_type(7'h00, 5'd4, 5'd5, 3'b100, 5'd6));
            emit(r_type(7'h00, 5'd5, 5'd6, 3'b001, 5'd7));
            emit(r_type(7'h20, 5'd6, 5'd7, 3'b101, 5'd8));
            emit(r_type(7'h00, 5'd7, 5'd8, 3'b011, 5'd9));
            v[3] = v[1] + {{20{imm[11]}}, imm};
            v[4] = v[3] + v[2];
            v[5] = v[4] - v[3];
            v[6] = v[5] ^ v[4];
            v[7] = v[6] << v[5][4:0];
            v[8] = word_t'($signed(v[7]) >>> v[6][4:0]);
            v[9] = {31'b0, v[8] < v[7]};
            // Youngest result first so store data is forwarded too
            for (int n = 9; n >= 3; n--) begin
                store_checked(reg_addr_t'(n), 32'h200 + word_t'(k * 64 + n * 4), v[n]);
            end
        end
        end_with_ecall();
    endfunction

    function automatic void load_use_program();
        word_t b;
        b = next_rand();
        load_const(5'd1, b);
        emit(i_type(12'h300, 5'd0, 3'b010, 5'd2, opc_load));
        emit(r_type(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));
        store_checked(5'd3, 32'h280, fill_word(32'h300) + b);
        emit(i_type(12'h304, 5'd0, 3'b010, 5'd4, opc_load));
        store_checked(5'd4, 32'h284, fill_word(32'h304));
        emit(i_type(12'h308, 5'd0, 3'b010, 5'd5, opc_load));
        emit(r_type(7'h00, 5'd5, 5'd1, 3'b000, 5'd6));
        store_checked(5'd6, 32'h288, fill_word(32'h308) + b);
        end_with_ecall();
    endfunction

    function automatic void branch_program();
        funct3_t   conds [8] = '{3'b000, 3'b000, 3'b001, 3'b001,
                                 3'b100, 3'b100, 3'b111, 3'b111};
        reg_addr_t lhs [8]   = '{5'd1, 5'd1, 5'd1, 5'd1, 5'd1, 5'd2, 5'd1, 5'd2};
        reg_addr_t rhs [8]   = '{5'd3, 5'd2, 5'd2, 5'd3, 5'd2, 5'd1, 5'd2, 5'd1};
        word_t     vals [32];
        word_t     skip;
        vals[1] = next_rand();
        vals[2] = next_rand();
        vals[3] = vals[1];
        load_const(5'd1, vals[1]);
        load_const(5'd2, vals[2]);
        load_const(5'd3, vals[3]);
        load_const(5'd10, branch_marker);
        for (int k = 0; k < 8; k++) begin
            skip = 32'h400 + word_t'(k * 8);
            emit(b_type(13'd8, rhs[k], lhs[k], conds[k]));
            // Left unexpected when taken so a write there fails
            if (branch_taken(conds[k], vals[lhs[k]], vals[rhs[k]])) begin
                emit(s_type(skip[11:0], 5'd10, 5'd0));
            end else begin
                store_checked(5'd10, skip, branch_marker);
            end
            store_checked(5'd10, skip + 32'd4, branch_marker);
        end
        end_with_ecall();
    endfunction

    function automatic void jump_program();
        word_t p;
        word_t t;
        load_const(5'd10, jump_marker);
        p = next_pc();
        emit(j_type(21'd12, 5'd1));
        emit(s_type(12'h500, 5'd10, 5'd0));
        emit(s_type(12'h504, 5'd10, 5'd0));
        store_checked(5'd1, 32'h508, p + 32'd4);
        // JALR to an odd sum drops bit 0
        p = next_pc();
        t = p + 32'd16;
        emit(i_type(t[11:0], 5'd0, 3'b000, 5'd5, opc_op_imm));
        emit(i_type(12'd1, 5'd5, 3'b000, 5'd2, opc_jalr));
        emit(s_type(12'h50c, 5'd10, 5'd0));
        emit(s_type(12'h510, 5'd10, 5'd0));
        store_checked(5'd2, 32'h514, p + 32'd8);
        store_checked(5'd10, 32'h518, jump_marker);
        end_with_ecall();
    endfunction

    function automatic void upper_imm_program();
        word_t r;
        word_t p;
        for (int k = 0; k < 2; k++) begin
            r = next_rand();
            emit(u_type(r[19:0], 5'd1, opc_lui));
            store_checked(5'd1, 32'h600 + word_t'(k * 16), {r[19:0], 12'b0});
            r = next_rand();
            p = next_pc();
            emit(u_type(r[19:0], 5'd2, opc_auipc));
            store_checked(5'd2, 32'h604 + word_t'(k * 16), p + {r[19:0], 12'b0});
        end
        end_with_ecall();
    endfunction

    // ==================================================
    // Test sequencing
    // ==================================================
    task automatic enter_reset();
        @(posedge clk);
        #1;
        rst = 1'b1;
        prog.delete();
        for (int i = 0; i < dmem_words; i++) begin
            exp_valid[i] = 1'b0;
        end
    endtask

    task automatic run_program(input string name);
        int errors_before;
        errors_before = errors;
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : '0;
        end
        cycle_limit = cycle_limit + 200 * prog.size() + 8;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        do begin
            @(negedge clk);
        end while (!halt);
        for (int i = 0; i < dmem_words; i++) begin
            if (exp_valid[i]) begin
                assert (store_seen[i] && dmem[i] == exp_word[i])
                else begin
                    errors++;
                    $display("Mismatch at %0t: word %h holds %h, expected %h", $time,
                             word_t'(i) << 2, dmem[i], exp_word[i]);
                end
            end
        end
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("Test %s finished at %0t with %0d errors", name, $time, errors - errors_before);
    endtask

    initial begin
        rst = 1'b1;
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = '0;
        end
        enter_reset();
        alu_chain_program();
        run_program("alu_chain");
        enter_reset();
        load_use_program();
        run_program("load_use");
        enter_reset();
        branch_program();
        run_program("branches");
        enter_reset();
        jump_program();
        run_program("jumps");
        enter_reset();
        upper_imm_program();
        run_program("lui_auipc");
        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- rv_core.f
hw/rv_pkg.sv
hw/rv_regfile.sv
hw/rv_decode.sv
hw/rv_hazard.sv
hw/rv_alu.sv
hw/rv_core.sv
verif/rv_core_tb.sv

//--- Makefile
TOP := rv_core_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f rv_core.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
